// File: design/cpu_pkg.sv
// cpu front-end package: word types, opcode and ALU enums, cache geometry, control word, Wishbone structs
`default_nettype none

package cpu_pkg;

	typedef logic [15:0] word_t;	// instruction or data word
	typedef logic [15:0] addr_t;	// word address

	// opcode sits in the top four bits of every instruction
	typedef enum logic [3:0] {
		ADD  = 4'd0,
		SUB  = 4'd1,
		NAND = 4'd2,
		XOR  = 4'd3,
		INC  = 4'd4,
		SRA  = 4'd5,
		SRL  = 4'd6,
		SLL  = 4'd7,
		LW   = 4'd8,
		SW   = 4'd9,
		LHB  = 4'd10,
		LLB  = 4'd11,
		B    = 4'd12,
		CALL = 4'd13,
		RET  = 4'd14,
		HLT  = 4'd15
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD  = 3'd0,
		ALU_SUB  = 3'd1,
		ALU_NAND = 3'd2,
		ALU_XOR  = 3'd3,
		ALU_INC  = 3'd4,
		ALU_SRA  = 3'd5,
		ALU_SRL  = 3'd6,
		ALU_SLL  = 3'd7
	} alu_op_e;	// same code as the low opcode bits

	// decoded control word handed to execute
	typedef struct packed {
		logic    data_reg;	// read_data_1 from the data segment register
		logic    stack_reg;	// read_data_1 from the stack pointer
		logic    call;
		logic    rtrn;
		logic    branch;
		logic    mem_to_reg;	// load result goes to the register file
		alu_op_e alu_op;
		logic    alu_src;	// immediate as second operand
		logic    sign_ext_sel;
		logic    reg_rt_src;	// read_reg_2 from rt field
		logic    reg_write;
		logic    mem_write;
		logic    mem_read;
		logic    load_half;
		logic    half_spec;	// 0 for LHB, 1 for LLB
		logic    halt;
	} ctrl_t;

	// direct-mapped instruction cache geometry
	localparam int LINE_WORDS = 4;
	localparam int OFFSET_W   = 2;
	localparam int LINES      = 16;
	localparam int INDEX_W    = 4;
	localparam int TAG_W      = 10;

	typedef struct packed {
		logic             valid;
		logic [TAG_W-1:0] tag;
	} tag_entry_t;

	typedef word_t [LINE_WORDS-1:0] line_t;

	// Wishbone classic master request, read only
	typedef struct packed {
		logic  cyc;
		logic  stb;
		logic  we;
		addr_t adr;
	} wb_req_t;

	typedef struct packed {
		logic  ack;
		word_t dat;
	} wb_rsp_t;

	typedef struct packed {
		logic  valid;
		addr_t pc;
		ctrl_t ctrl;
	} fetch_out_t;

endpackage

`default_nettype wire

// File: design/control_logic.sv
// opcode decoder producing the control word
`default_nettype none

module control_logic (
	input  cpu_pkg::opcode_e opcode,
	output cpu_pkg::ctrl_t   ctrl
);

	always_comb begin
		ctrl = '0;	// unlisted fields stay inactive
		case (opcode)
			cpu_pkg::ADD,
			cpu_pkg::SUB,
			cpu_pkg::NAND,
			cpu_pkg::XOR,
			cpu_pkg::SRA,
			cpu_pkg::SRL,
			cpu_pkg::SLL: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_op    = cpu_pkg::alu_op_e'(opcode[2:0]);
			end
			cpu_pkg::INC: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_op    = cpu_pkg::alu_op_e'(opcode[2:0]);
				ctrl.alu_src   = 1'b1;	// increment by immediate
			end
			cpu_pkg::LW: begin
				ctrl.data_reg     = 1'b1;
				ctrl.mem_to_reg   = 1'b1;
				ctrl.alu_op       = cpu_pkg::ALU_ADD;	// base plus offset
				ctrl.alu_src      = 1'b1;
				ctrl.sign_ext_sel = 1'b1;
				ctrl.reg_write    = 1'b1;
				ctrl.mem_read     = 1'b1;
			end
			cpu_pkg::SW: begin
				ctrl.data_reg     = 1'b1;
				ctrl.alu_op       = cpu_pkg::ALU_ADD;
				ctrl.alu_src      = 1'b1;
				ctrl.sign_ext_sel = 1'b1;
				ctrl.reg_rt_src   = 1'b1;	// store data comes from rt
				ctrl.mem_write    = 1'b1;
			end
			cpu_pkg::LHB: begin
				ctrl.reg_rt_src = 1'b1;
				ctrl.reg_write  = 1'b1;
				ctrl.load_half  = 1'b1;
			end
			cpu_pkg::LLB: begin
				ctrl.reg_rt_src = 1'b1;
				ctrl.reg_write  = 1'b1;
				ctrl.load_half  = 1'b1;
				ctrl.half_spec  = 1'b1;	// low byte
			end
			cpu_pkg::B: begin
				ctrl.branch       = 1'b1;
				ctrl.sign_ext_sel = 1'b1;
				ctrl.alu_op       = cpu_pkg::ALU_ADD;	// target offset add
			end
			cpu_pkg::CALL: begin
				ctrl.stack_reg = 1'b1;
				ctrl.call      = 1'b1;
				ctrl.alu_op    = cpu_pkg::ALU_ADD;
				ctrl.reg_write = 1'b1;	// stack pointer update
				ctrl.mem_write = 1'b1;	// push return address
			end
			cpu_pkg::RET: begin
				ctrl.stack_reg = 1'b1;
				ctrl.rtrn      = 1'b1;
				ctrl.alu_op    = cpu_pkg::ALU_ADD;
				ctrl.reg_write = 1'b1;
				ctrl.mem_read  = 1'b1;	// pop return address
			end
			cpu_pkg::HLT: begin
				ctrl.halt = 1'b1;
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: design/cache_ram.sv
// synchronous single-port storage with registered write-first read and a type-parameterized entry
`default_nettype none

module cache_ram #(
	parameter type entry_t = cpu_pkg::word_t
) (
	input  logic                        clk,
	input  logic [cpu_pkg::INDEX_W-1:0] addr,
	input  logic                        we,
	input  entry_t                      wdata,
	output entry_t                      rdata
);

	entry_t mem [cpu_pkg::LINES];	// one entry per cache line

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
			rdata     <= wdata;	// written entry is visible on the next cycle
		end else begin
			rdata <= mem[addr];
		end
	end

endmodule

`default_nettype wire

// File: design/icache_ctrl.sv
// instruction cache controller: tag compare, hit/miss FSM, Wishbone refill master
`default_nettype none

module icache_ctrl (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        req_valid,
	input  cpu_pkg::addr_t              req_addr,
	output logic                        rsp_valid,
	output cpu_pkg::word_t              rsp_word,
	output logic [cpu_pkg::INDEX_W-1:0] tag_addr,
	output logic                        tag_we,
	output cpu_pkg::tag_entry_t         tag_wdata,
	input  cpu_pkg::tag_entry_t         tag_rdata,
	output logic [cpu_pkg::INDEX_W-1:0] line_addr,
	output logic                        line_we,
	output cpu_pkg::line_t              line_wdata,
	input  cpu_pkg::line_t              line_rdata,
	output cpu_pkg::wb_req_t            wb_req,
	input  cpu_pkg::wb_rsp_t            wb_rsp
);

	typedef enum logic [1:0] {
		CLEAR,
		IDLE,
		COMPARE_TAG,
		ALLOCATE
	} state_e;

	state_e                       state;
	cpu_pkg::addr_t               req_q;	// address being served
	logic [cpu_pkg::INDEX_W-1:0]  clr_idx;	// tag sweep after reset
	logic [cpu_pkg::OFFSET_W-1:0] word_cnt;	// next word of the refill
	cpu_pkg::line_t               line_buf;
	logic                         cyc;
	logic [cpu_pkg::INDEX_W-1:0]  idx;
	logic                         hit;
	logic                         ack;
	logic                         last_ack;

	assign hit      = tag_rdata.valid && (tag_rdata.tag == req_q[15 -: cpu_pkg::TAG_W]);
	assign ack      = cyc && wb_rsp.ack;
	assign last_ack = ack && (int'(word_cnt) == cpu_pkg::LINE_WORDS - 1);

	// both stores share the line index
	always_comb begin
		case (state)
			CLEAR:   idx = clr_idx;
			IDLE:    idx = req_addr[cpu_pkg::OFFSET_W +: cpu_pkg::INDEX_W];	// read ahead
			default: idx = req_q[cpu_pkg::OFFSET_W +: cpu_pkg::INDEX_W];
		endcase
	end

	assign tag_addr  = idx;
	assign line_addr = idx;
	assign tag_we    = (state == CLEAR) || last_ack;
	assign line_we   = last_ack;

	always_comb begin
		tag_wdata = '0;	// invalid entry while sweeping
		if (state != CLEAR) begin
			tag_wdata.valid = 1'b1;
			tag_wdata.tag   = req_q[15 -: cpu_pkg::TAG_W];
		end
		line_wdata           = line_buf;
		line_wdata[word_cnt] = wb_rsp.dat;	// last word straight from the bus
	end

	assign wb_req.cyc = cyc;
	assign wb_req.stb = cyc;
	assign wb_req.we  = 1'b0;
	assign wb_req.adr = {req_q[15:cpu_pkg::OFFSET_W], word_cnt};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= CLEAR;
			clr_idx   <= '0;
			word_cnt  <= '0;
			cyc       <= 1'b0;
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= 1'b0;
			case (state)
				CLEAR: begin
					clr_idx <= clr_idx + 1'b1;
					if (int'(clr_idx) == cpu_pkg::LINES - 1)
						state <= IDLE;
				end
				IDLE: begin
					if (req_valid)
						state <= COMPARE_TAG;
				end
				COMPARE_TAG: begin
					if (hit) begin
						rsp_valid <= 1'b1;
						state     <= IDLE;
					end else begin
						word_cnt <= '0;
						state    <= ALLOCATE;
					end
				end
				ALLOCATE: begin
					if (!cyc) begin
						cyc <= 1'b1;	// one idle cycle between reads
					end else if (wb_rsp.ack) begin
						cyc      <= 1'b0;
						word_cnt <= word_cnt + 1'b1;
						if (last_ack)
							state <= COMPARE_TAG;	// line written, compare again
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && req_valid)
			req_q <= req_addr;
		if (ack)
			line_buf[word_cnt] <= wb_rsp.dat;
		if (state == COMPARE_TAG)
			rsp_word <= line_rdata[req_q[cpu_pkg::OFFSET_W-1:0]];
	end

endmodule

`default_nettype wire

// File: design/fetch_unit.sv
// fetch unit: program counter, redirect, halt latch and output register toward execute
`default_nettype none

module fetch_unit (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                redirect_valid,
	input  cpu_pkg::addr_t      redirect_pc,
	input  logic                stall,
	output logic                req_valid,
	output cpu_pkg::addr_t      req_addr,
	input  logic                rsp_valid,
	input  cpu_pkg::ctrl_t      ctrl,
	output cpu_pkg::fetch_out_t fetch_out
);

	cpu_pkg::addr_t      pc;
	logic                outstanding;	// request sent, response not yet back
	logic                drop;	// returning word is from before a redirect
	logic                halted;
	logic                take;
	cpu_pkg::fetch_out_t rsp_entry;
	cpu_pkg::fetch_out_t held;	// response that came in during stall

	assign req_addr  = pc;
	assign req_valid = !halted && !stall && !rsp_valid && !redirect_valid;
	assign take      = rsp_valid && !drop && !redirect_valid;

	always_comb begin
		rsp_entry.valid = take;
		rsp_entry.pc    = pc;
		rsp_entry.ctrl  = ctrl;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc          <= '0;
			outstanding <= 1'b0;
			drop        <= 1'b0;
			halted      <= 1'b0;
			fetch_out   <= '0;
			held        <= '0;
		end else begin
			if (rsp_valid)
				outstanding <= 1'b0;
			else if (req_valid)
				outstanding <= 1'b1;

			if (redirect_valid) begin
				pc              <= redirect_pc;
				halted          <= 1'b0;
				drop            <= outstanding && !rsp_valid;
				fetch_out.valid <= 1'b0;
				held.valid      <= 1'b0;
			end else begin
				if (rsp_valid)
					drop <= 1'b0;
				if (take) begin
					pc <= pc + 1'b1;
					if (ctrl.halt)
						halted <= 1'b1;
				end
				if (!stall) begin
					if (held.valid) begin
						fetch_out  <= held;
						held.valid <= 1'b0;
					end else begin
						fetch_out <= rsp_entry;
					end
				end else if (take) begin
					held <= rsp_entry;	// fetch_out holds, park the word
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: design/fetch_decode_top.sv
// top level: fetch unit, instruction cache controller, tag and line stores, decoder
`default_nettype none

module fetch_decode_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                redirect_valid,
	input  cpu_pkg::addr_t      redirect_pc,
	input  logic                stall,
	output cpu_pkg::fetch_out_t fetch_out,
	output cpu_pkg::wb_req_t    wb_req,
	input  cpu_pkg::wb_rsp_t    wb_rsp
);

	logic                        req_valid;
	cpu_pkg::addr_t              req_addr;
	logic                        rsp_valid;
	cpu_pkg::word_t              rsp_word;
	cpu_pkg::ctrl_t              ctrl;
	logic [cpu_pkg::INDEX_W-1:0] tag_addr;
	logic                        tag_we;
	cpu_pkg::tag_entry_t         tag_wdata;
	cpu_pkg::tag_entry_t         tag_rdata;
	logic [cpu_pkg::INDEX_W-1:0] line_addr;
	logic                        line_we;
	cpu_pkg::line_t              line_wdata;
	cpu_pkg::line_t              line_rdata;

	fetch_unit u_fetch (
		.clk            (clk),
		.rst_n          (rst_n),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.stall          (stall),
		.req_valid      (req_valid),
		.req_addr       (req_addr),
		.rsp_valid      (rsp_valid),
		.ctrl           (ctrl),
		.fetch_out      (fetch_out)
	);

	icache_ctrl u_icache (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req_addr   (req_addr),
		.rsp_valid  (rsp_valid),
		.rsp_word   (rsp_word),
		.tag_addr   (tag_addr),
		.tag_we     (tag_we),
		.tag_wdata  (tag_wdata),
		.tag_rdata  (tag_rdata),
		.line_addr  (line_addr),
		.line_we    (line_we),
		.line_wdata (line_wdata),
		.line_rdata (line_rdata),
		.wb_req     (wb_req),
		.wb_rsp     (wb_rsp)
	);

	cache_ram #(.entry_t(cpu_pkg::tag_entry_t)) u_tag_ram (
		.clk   (clk),
		.addr  (tag_addr),
		.we    (tag_we),
		.wdata (tag_wdata),
		.rdata (tag_rdata)
	);

	cache_ram #(.entry_t(cpu_pkg::line_t)) u_line_ram (
		.clk   (clk),
		.addr  (line_addr),
		.we    (line_we),
		.wdata (line_wdata),
		.rdata (line_rdata)
	);

	// opcode is the top nibble of the returned word
	control_logic u_decode (
		.opcode (cpu_pkg::opcode_e'(rsp_word[15:12])),
		.ctrl   (ctrl)
	);

endmodule

`default_nettype wire

// File: test/wb_mem_model.sv
// Wishbone classic slave memory model with rule-based instruction words and random wait states
`default_nettype none

module wb_mem_model (
	input  logic              clk,
	input  logic              rst_n,
	input  cpu_pkg::wb_req_t  wb_req,
	output cpu_pkg::wb_rsp_t  wb_rsp
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [31:0] lfsr;
	logic [31:0] lfsr_1;	// after the first bit is taken
	logic [31:0] lfsr_2;
	logic [1:0]  wait_left;	// wait cycles before the next ack

	// galois step for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	assign lfsr_1 = lfsr_step(lfsr);
	assign lfsr_2 = lfsr_step(lfsr_1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lfsr      <= 32'h5439_2020;
			wait_left <= '0;
		end else if (wb_req.cyc && wb_req.stb) begin
			if (wait_left == 2'd0) begin
				wait_left <= {lfsr_1[0], lfsr[0]};	// two bits, one step each
				lfsr      <= lfsr_2;
			end else begin
				wait_left <= wait_left - 2'd1;
			end
		end
	end

	// ack is combinational, so it can come in the first stb cycle
	always_comb begin
		wb_rsp.ack = wb_req.cyc && wb_req.stb && (wait_left == 2'd0);
		wb_rsp.dat = '0;
		if (wb_rsp.ack)
			wb_rsp.dat = {wb_req.adr[3:0] ^ wb_req.adr[7:4], wb_req.adr[11:0]};
	end

endmodule

`default_nettype wire

// File: test/tb_top.sv
// testbench: clock, reset, stimulus table, reference model, compare tasks and timeout
`default_nettype none

module tb_top;

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		cpu_pkg::addr_t pc;	// redirect target
		int             n;	// outputs to collect
		int             m;	// stall after every m-th output, 0 for none
		int             k;	// stall length in cycles
		int             reads;	// expected Wishbone reads, -1 unchecked
		logic           cut;	// redirect away from a miss on cut_pc first
		cpu_pkg::addr_t cut_pc;
	} row_t;

	row_t rows [6] = '{
		'{16'h0000, 16, 0, 0, 16, 1'b0, 16'h0000},	// all sixteen opcodes, first visit
		'{16'h0004, 16, 0, 0,  0, 1'b0, 16'h0000},	// revisit, hits only
		'{16'h03f8, 20, 3, 2, -1, 1'b0, 16'h0000},	// line crossings under stall
		'{16'h0900,  6, 1, 1, -1, 1'b1, 16'h0810},	// redirect away from a SUB word during its miss
		'{16'h03f8,  7, 2, 3,  0, 1'b0, 16'h0000},
		'{16'h00a0, 20, 5, 1, -1, 1'b0, 16'h0000}	// halts at 00a5
	};

	logic                clk;
	logic                rst_n;
	logic                redirect_valid;
	cpu_pkg::addr_t      redirect_pc;
	logic                stall;
	cpu_pkg::fetch_out_t fetch_out;
	cpu_pkg::wb_req_t    wb_req;
	cpu_pkg::wb_rsp_t    wb_rsp;

	cpu_pkg::fetch_out_t fo;	// fetch_out sampled at the last edge
	logic                st;
	cpu_pkg::addr_t      reads [$];	// acked read addresses of the current row
	int                  cycles;
	int                  limit;

	fetch_decode_top u_dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.stall          (stall),
		.fetch_out      (fetch_out),
		.wb_req         (wb_req),
		.wb_rsp         (wb_rsp)
	);

	wb_mem_model u_mem (
		.clk    (clk),
		.rst_n  (rst_n),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stop_with_failure(string line);
		$display("%s", line);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_pc(string name, cpu_pkg::addr_t got, cpu_pkg::addr_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("Fail %0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_ctrl(string name, cpu_pkg::ctrl_t got, cpu_pkg::ctrl_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("Fail %0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		if (got !== exp)
			stop_with_failure($sformatf("Fail %0t %s got %b expected %b", $time, name, got, exp));
	endtask

	task automatic check_count(string name, int got, int exp);
		if (got != exp)
			stop_with_failure($sformatf("Fail %0t %s got %0d expected %0d", $time, name, got, exp));
	endtask

	// instruction memory contents
	function automatic cpu_pkg::word_t mem_word(cpu_pkg::addr_t a);
		return {a[3:0] ^ a[7:4], a[11:0]};
	endfunction

	// reference decode table
	function automatic cpu_pkg::ctrl_t expected_ctrl(cpu_pkg::word_t w);
		cpu_pkg::ctrl_t c;
		logic [3:0]     op;
		c  = '0;
		op = w[15:12];
		if (op < 4'd8) begin
			c.reg_write = 1'b1;
			c.alu_op    = cpu_pkg::alu_op_e'(op[2:0]);
			c.alu_src   = (op == 4'd4);	// inc uses the immediate
		end else begin
			case (op)
				4'd8:  {c.data_reg, c.mem_to_reg, c.alu_src, c.sign_ext_sel, c.reg_write,
					c.mem_read} = 6'b111111;
				4'd9:  {c.data_reg, c.alu_src, c.sign_ext_sel, c.reg_rt_src,
					c.mem_write} = 5'b11111;
				4'd10: {c.reg_rt_src, c.reg_write, c.load_half} = 3'b111;
				4'd11: {c.reg_rt_src, c.reg_write, c.load_half, c.half_spec} = 4'b1111;
				4'd12: {c.branch, c.sign_ext_sel} = 2'b11;
				4'd13: {c.stack_reg, c.call, c.reg_write, c.mem_write} = 4'b1111;
				4'd14: {c.stack_reg, c.rtrn, c.reg_write, c.mem_read} = 4'b1111;
				default: c.halt = 1'b1;
			endcase
		end
		return c;
	endfunction

	// one clock: sample outputs, log Wishbone reads, watch the cycle budget
	task automatic tick();
		@(posedge clk);
		cycles++;
		if (cycles > limit)
			stop_with_failure($sformatf("timeout: run exceeded %0d cycles", limit));
		fo = fetch_out;
		st = stall;
		check_flag("wb_req.we", wb_req.we, 1'b0);	// read-only master
		if (wb_req.cyc && wb_req.stb && wb_rsp.ack)
			reads.push_back(wb_req.adr);
	endtask

	task automatic apply_redirect(cpu_pkg::addr_t pc);
		redirect_pc    <= pc;
		redirect_valid <= 1'b1;
		tick();
		redirect_valid <= 1'b0;
	endtask

	task automatic run_row(row_t r);
		int                  got;
		int                  stall_left;
		logic                done;
		logic                prev_st;
		cpu_pkg::addr_t      exp_pc;
		cpu_pkg::fetch_out_t prev;
		reads.delete();
		if (r.cut) begin
			apply_redirect(r.cut_pc);
			while (!(wb_req.cyc && wb_req.adr[15:2] == r.cut_pc[15:2]))
				tick();	// refill of the stale line has started
		end
		apply_redirect(r.pc);
		exp_pc     = r.pc;
		got        = 0;
		stall_left = 0;
		done       = 1'b0;
		prev_st    = 1'b0;
		prev       = fo;
		while (!done) begin
			tick();
			if (prev_st) begin	// register frozen over a stalled cycle
				check_flag("fetch_out.valid", fo.valid, prev.valid);
				check_pc("fetch_out.pc", fo.pc, prev.pc);
				check_ctrl("fetch_out.ctrl", fo.ctrl, prev.ctrl);
			end
			if (st) begin
				stall_left--;
				if (stall_left == 0)
					stall <= 1'b0;
			end else if (fo.valid) begin
				check_pc("fetch_out.pc", fo.pc, exp_pc);
				check_ctrl("fetch_out.ctrl", fo.ctrl, expected_ctrl(mem_word(exp_pc)));
				got++;
				exp_pc++;
				if (fo.ctrl.halt || got == r.n) begin
					done = 1'b1;
					stall <= 1'b0;
				end else if (r.m > 0 && got % r.m == 0) begin
					stall      <= 1'b1;
					stall_left = r.k;
				end
			end
			prev    = fo;
			prev_st = st;
		end
		if (fo.ctrl.halt) begin
			repeat (30) begin
				tick();
				check_flag("fetch_out.valid after halt", fo.valid, 1'b0);
			end
		end
		if (r.reads >= 0) begin
			check_count("wishbone reads", reads.size(), r.reads);
			for (int i = 0; i < reads.size(); i++)
				check_pc("wb_req.adr", reads[i], cpu_pkg::addr_t'((r.pc & 16'hfffc) + i));
		end
	endtask

	initial begin
		rst_n          = 1'b0;
		redirect_valid = 1'b0;
		redirect_pc    = '0;
		stall          = 1'b0;
		cycles         = 0;
		limit          = 100;
		foreach (rows[i])
			limit += rows[i].n * 24;
		repeat (4) tick();
		rst_n <= 1'b1;
		foreach (rows[i])
			run_row(rows[i]);
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
design/cpu_pkg.sv
design/control_logic.sv
design/cache_ram.sv
design/icache_ctrl.sv
design/fetch_unit.sv
design/fetch_decode_top.sv
test/wb_mem_model.sv
test/tb_top.sv
